/* verilog/dsp_ctrl_pkg.sv */
/*
 * Shared types and constants for the DSP16-style decode and issue stage.
 * Holds the T field codes, the Y pointer step encoding and the two
 * control structs passed from the decoders to the issue stage.
 */

package dsp_ctrl_pkg;

    typedef logic [15:0] word_t;      // Instruction or immediate word
    typedef logic [4:0]  t_code_t;    // T field, insn[15:11]
    typedef logic [2:0]  reg_sel_t;   // r_field and rsel
    typedef logic [1:0]  acc_sel_t;   // a_field
    typedef logic [10:0] do_data_t;   // Loop count and length
    typedef logic [8:0]  short_imm_t;

    // T codes. Pairs that ignore bit 11 are named by their even value
    localparam t_code_t T_GOTO_JA   = 5'b00000;
    localparam t_code_t T_SHORT_IMM = 5'b00010;
    localparam t_code_t T_CALL_JA   = 5'b10000;
    localparam t_code_t T_GOTO_B    = 5'b11000;
    localparam t_code_t T_R_ACC0    = 5'b01001;
    localparam t_code_t T_R_ACC1    = 5'b01011;
    localparam t_code_t T_LONG_IMM  = 5'b01010;
    localparam t_code_t T_RAM_LOAD  = 5'b01111;
    localparam t_code_t T_RAM_STORE = 5'b01100;
    localparam t_code_t T_F1_Y      = 5'b00110;
    localparam t_code_t T_F1_AY     = 5'b00111;
    localparam t_code_t T_F1_XY     = 5'b10110;
    localparam t_code_t T_IF_CON    = 5'b11010;
    localparam t_code_t T_DO        = 5'b01110;

    // Destination groups for long immediate and RAM loads
    localparam reg_sel_t DEST_YAAU = 3'd0;
    localparam reg_sel_t DEST_DAU  = 3'd2;

    // Short immediate targets j, k, rb, re sit at the top of the map
    localparam reg_sel_t SHORT_R_FLIP = 3'b100;

    // Values line up with the YAAU inc_sel codes
    typedef enum logic [1:0] {
        Y_DEC    = 2'd0,  // *rN--
        Y_HOLD   = 2'd1,  // *rN
        Y_INC    = 2'd2,  // *rN++
        Y_STEP_J = 2'd3   // *rN++j
    } y_step_t;

    typedef struct packed {
        logic     goto_ja;
        logic     call_ja;
        logic     goto_b;
        logic     iret;
        logic     con_check;  // Next instruction is conditional
        logic     do_start;
        do_data_t do_data;
        logic     two_cycle;
        logic     pc_halt;
        logic     fault;      // Unsupported T code
    } seq_ctl_t;

    typedef struct packed {
        logic       short_load;
        logic       long_load;
        logic       acc_load;
        logic       ram_load;
        logic       ram_we;
        logic       post_load;  // Y pointer update
        logic [1:0] y_field;
        y_step_t    y_step;
        reg_sel_t   r_field;
        reg_sel_t   rsel;
        acc_sel_t   a_field;
        logic       acc_sel;
        logic       dau_dec_en;
        logic       dau_imm_load;
        logic       dau_acc_load;
        logic       dau_ram_load;
        logic       dau_acc_ram;
        logic       st_a0h;
        logic       st_a1h;
        short_imm_t short_imm;
    } move_ctl_t;

endpackage

/* verilog/seq_decode.sv */
/*
 * Sequencing decode of one instruction word, purely combinational.
 * Produces branch requests, do-loop start, the condition latch request
 * and instruction length. Any T code outside the supported set flags
 * a fault. Branch gating is left to the issue stage.
 */

`timescale 1ns/1ps

module seq_decode (
    input  dsp_ctrl_pkg::word_t    insn,
    output dsp_ctrl_pkg::seq_ctl_t seq_next
);
    import dsp_ctrl_pkg::*;

    t_code_t t_code;

    assign t_code = insn[15:11];

    always_comb begin
        seq_next = '0;
        case (t_code)
            T_GOTO_JA, T_GOTO_JA | 5'd1: begin
                seq_next.goto_ja   = 1'b1;
                seq_next.two_cycle = 1'b1;
                seq_next.pc_halt   = 1'b1;
            end

            T_CALL_JA, T_CALL_JA | 5'd1: begin
                seq_next.call_ja   = 1'b1;
                seq_next.two_cycle = 1'b1;
                seq_next.pc_halt   = 1'b1;
            end

            T_GOTO_B: begin // ret, iret, goto pt, call pt
                seq_next.goto_b    = 1'b1;
                seq_next.iret      = (insn[10:8] == 3'd1);
                seq_next.two_cycle = 1'b1;
                seq_next.pc_halt   = 1'b1;
            end

            T_IF_CON: begin
                // icall variant has bit 10 set and does nothing here
                seq_next.con_check = ~insn[10];
            end

            T_DO: begin
                seq_next.do_start  = 1'b1;
                seq_next.do_data   = insn[10:0];
                // Zero length means redo, which refetches
                seq_next.two_cycle = (insn[10:7] == 4'd0);
                seq_next.pc_halt   = (insn[10:7] == 4'd0);
            end

            T_LONG_IMM: begin
                seq_next.two_cycle = 1'b1; // Second word is the data, pc runs on
            end

            T_R_ACC0, T_R_ACC1, T_RAM_LOAD, T_RAM_STORE: begin
                seq_next.two_cycle = 1'b1;
                seq_next.pc_halt   = 1'b1;
            end

            // Single cycle, nothing to sequence
            T_SHORT_IMM, T_SHORT_IMM | 5'd1, T_F1_Y, T_F1_AY, T_F1_XY: begin
                seq_next.fault = 1'b0;
            end

            default: begin
                seq_next.fault = 1'b1;
            end
        endcase
    end

endmodule

/* verilog/move_decode.sv */
/*
 * Data-move decode of one instruction word, purely combinational.
 * Selects register loads, RAM access, accumulator routing, DAU enables
 * and the Y pointer post-modify. Codes it does not handle give all zero.
 */

`timescale 1ns/1ps

module move_decode (
    input  dsp_ctrl_pkg::word_t     insn,
    output dsp_ctrl_pkg::move_ctl_t move_next
);
    import dsp_ctrl_pkg::*;

    t_code_t  t_code;
    reg_sel_t dest;     // Destination group of loads
    y_step_t  y_step;

    assign t_code = insn[15:11];
    assign dest   = insn[9:7];

    // Post-modify of the Y pointer from the low two bits
    always_comb begin
        case (insn[1:0])
            2'd0:    y_step = Y_HOLD;
            2'd1:    y_step = Y_INC;
            2'd2:    y_step = Y_DEC;
            default: y_step = Y_STEP_J;
        endcase
    end

    always_comb begin
        move_next = '0;
        case (t_code)
            T_SHORT_IMM, T_SHORT_IMM | 5'd1: begin // j, k, rb, re
                move_next.short_load = 1'b1;
                move_next.short_imm  = insn[8:0];
                move_next.r_field    = insn[11:9] ^ SHORT_R_FLIP;
            end

            T_LONG_IMM: begin
                move_next.long_load    = (dest == DEST_YAAU);
                move_next.dau_imm_load = (dest == DEST_DAU);
                move_next.r_field      = insn[6:4];
            end

            T_R_ACC0, T_R_ACC1: begin
                move_next.r_field      = insn[6:4];
                move_next.a_field      = {1'b1, insn[12]}; // a0 or a1
                move_next.acc_sel      = 1'b1;
                move_next.acc_load     = (insn[8:7] == 2'd0);
                move_next.dau_acc_load = (insn[8:7] == 2'd2);
            end

            T_RAM_LOAD, T_RAM_STORE: begin
                move_next.rsel      = insn[8:6];
                move_next.r_field   = insn[6:4];
                move_next.post_load = 1'b1;
                move_next.y_field   = insn[3:2];
                move_next.y_step    = y_step;
                if (t_code == T_RAM_STORE) begin
                    move_next.ram_we = 1'b1;
                end else if (!insn[10]) begin
                    move_next.ram_load     = (dest == DEST_YAAU);
                    move_next.dau_ram_load = (dest == DEST_DAU);
                end
            end

            T_F1_Y, T_F1_AY: begin
                move_next.dau_dec_en = 1'b1;
                move_next.a_field    = insn[10:9];
                move_next.post_load  = 1'b1;
                move_next.y_field    = insn[3:2];
                move_next.y_step     = y_step;
                // Accumulator high half goes to RAM
                if (insn[11]) begin
                    move_next.dau_acc_ram = 1'b1;
                    move_next.st_a0h      = insn[10];
                    move_next.st_a1h      = ~insn[10];
                end
            end

            T_F1_XY: begin
                move_next.dau_dec_en   = 1'b1;
                move_next.dau_ram_load = 1'b1;
                move_next.r_field      = 3'd0; // x register
                move_next.post_load    = 1'b1;
                move_next.y_field      = insn[3:2];
                move_next.y_step       = y_step;
            end

            default: begin
                move_next = '0;
            end
        endcase
    end

endmodule

/* verilog/issue_stage.sv */
/*
 * Issue register for both decodes. On each cen edge the stage either
 * drops the fetch that follows a two-cycle instruction or registers the
 * new decode, with branches gated by the pending condition.
 * The fault flag stays set until reset.
 */

`timescale 1ns/1ps

module issue_stage (
    input                                 clk,
    input                                 rst,
    input                                 cen,
    input                                 con_result,
    input  dsp_ctrl_pkg::seq_ctl_t  seq_next,
    input  dsp_ctrl_pkg::move_ctl_t move_next,
    output dsp_ctrl_pkg::seq_ctl_t  seq,
    output dsp_ctrl_pkg::move_ctl_t moves,
    output logic                          no_int
);
    import dsp_ctrl_pkg::*;

    logic      second;     // Second cycle of a two-cycle instruction pending
    logic      con_pend;
    logic      con_ok;
    seq_ctl_t  seq_d;
    move_ctl_t moves_d;

    // Condition comes from the last issued if CON
    assign con_pend = seq.con_check;
    assign con_ok   = ~con_pend | con_result;
    assign no_int   = ~second; // No interrupt between the two cycles

    always_comb begin
        if (second) begin
            seq_d       = '0;
            seq_d.fault = seq.fault;
            moves_d     = '0;
        end else begin
            seq_d         = seq_next;
            seq_d.goto_ja = seq_next.goto_ja & con_ok;
            seq_d.call_ja = seq_next.call_ja & con_ok;
            seq_d.goto_b  = seq_next.goto_b & (con_ok | seq_next.iret); // iret always taken
            seq_d.fault   = seq_next.fault | seq.fault;
            moves_d       = move_next;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seq    <= '0;
            moves  <= '0;
            second <= 1'b0;
        end else if (cen) begin
            seq    <= seq_d;
            moves  <= moves_d;
            second <= ~second & seq_next.two_cycle;
        end
    end

endmodule

/* verilog/dsp_ctrl.sv */
/*
 * Top level of the decode and issue stage.
 * Both decoders look at the same instruction word; the issue stage
 * registers their results. The raw word also leaves as long_imm.
 */

`timescale 1ns/1ps

module dsp_ctrl (
    input                                 clk,
    input                                 rst,
    input                                 cen,
    input  dsp_ctrl_pkg::word_t     insn,
    input                                 con_result,
    output dsp_ctrl_pkg::seq_ctl_t  seq,
    output dsp_ctrl_pkg::move_ctl_t moves,
    output dsp_ctrl_pkg::word_t     long_imm,
    output logic                          no_int
);
    import dsp_ctrl_pkg::*;

    seq_ctl_t  seq_next;
    move_ctl_t move_next;

    // Data word of a long immediate follows on the same bus
    assign long_imm = insn;

    seq_decode u_seq_decode (
        .insn     (insn),
        .seq_next (seq_next)
    );

    move_decode u_move_decode (
        .insn      (insn),
        .move_next (move_next)
    );

    issue_stage u_issue_stage (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .con_result (con_result),
        .seq_next   (seq_next),
        .move_next  (move_next),
        .seq        (seq),
        .moves      (moves),
        .no_int     (no_int)
    );

endmodule

/* sim/dsp_ctrl_assert.sv */
/*
 * Concurrent checks on the issue stage for branch exclusivity, the
 * dropped second cycle and the sticky fault. Attached to every
 * issue_stage by the bind at the end.
 */

`timescale 1ns/1ps

module dsp_ctrl_assert (
    input logic                    clk,
    input logic                    rst,
    input logic                    cen,
    input logic                    second,
    input dsp_ctrl_pkg::seq_ctl_t  seq,
    input dsp_ctrl_pkg::move_ctl_t moves
);
    int branch_fails = 0;
    int second_fails = 0;
    int fault_fails  = 0;

    a_one_branch: assert property (@(posedge clk) disable iff (rst)
        $onehot0({seq.goto_ja, seq.call_ja, seq.goto_b}))
        else begin
            branch_fails = branch_fails + 1;
            $error("more than one branch strobe at once");
        end

    // Dropped fetch leaves only fault
    a_second_empty: assert property (@(posedge clk) disable iff (rst)
        (cen && second) |=> (moves == '0 && {seq.goto_ja, seq.call_ja, seq.goto_b,
        seq.iret, seq.con_check, seq.do_start, seq.two_cycle, seq.pc_halt} == 8'd0))
        else begin
            second_fails = second_fails + 1;
            $error("strobes set in a cleared second cycle");
        end

    a_fault_sticky: assert property (@(posedge clk) disable iff (rst)
        seq.fault |=> seq.fault)
        else begin
            fault_fails = fault_fails + 1;
            $error("fault fell without reset");
        end

endmodule

bind issue_stage dsp_ctrl_assert u_assert (
    .clk    (clk),
    .rst    (rst),
    .cen    (cen),
    .second (second),
    .seq    (seq),
    .moves  (moves)
);

/* sim/tb_dsp_ctrl.sv */
/*
 * Testbench for the decode and issue stage. Drives random kept
 * instructions, cen gaps and condition results, and checks seq, moves,
 * no_int and long_imm against a reference model after every clock.
 */

`timescale 1ns/1ps

module tb_dsp_ctrl;
    import dsp_ctrl_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int N_ITER       = 150;
    localparam int TOTAL_CYCLES = 8 * N_ITER + 40; // All tests plus both resets

    logic      clk;
    logic      rst;
    logic      cen;
    logic      con_result;
    word_t     insn;
    word_t     long_imm;
    seq_ctl_t  seq;
    move_ctl_t moves;
    logic      no_int;

    seq_ctl_t  exp_seq;     // Model state
    move_ctl_t exp_moves;
    logic      exp_second;

    int errors;
    int checks;
    int test_errors_at;
    int tests_failed;
    int test_no;
    string group_name [12] = '{"seq.branch", "seq.con_check", "seq.do", "seq.length",
        "seq.fault", "moves.loads", "moves.y_post", "moves.regs", "moves.acc",
        "moves.dau", "moves.st", "moves.short_imm"};

    dsp_ctrl dut0 (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .insn       (insn),
        .con_result (con_result),
        .seq        (seq),
        .moves      (moves),
        .long_imm   (long_imm),
        .no_int     (no_int)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD + 1000);
        $display("Watchdog expired before the tests completed");
        $display("*** FAILED ***");
        $finish;
    end

    function automatic int rand_below(int n);
        return int'($urandom % n);
    endfunction

    function automatic logic coin();
        logic [31:0] r;
        r = $urandom;
        return r[0];
    endfunction

    function automatic logic kept_code(t_code_t t);
        t_code_t pair;
        pair = t & 5'b11110;
        return pair == T_GOTO_JA || pair == T_CALL_JA || pair == T_SHORT_IMM ||
            t inside {T_GOTO_B, T_R_ACC0, T_R_ACC1, T_LONG_IMM, T_RAM_LOAD, T_RAM_STORE,
                      T_F1_Y, T_F1_AY, T_F1_XY, T_IF_CON, T_DO};
    endfunction

    // Kinds 0-3 single cycle, 4-12 two cycle, 13 if CON, 14 do of any length
    function automatic word_t pick_insn(int kind);
        word_t       w;
        logic [31:0] r;
        r = $urandom;
        w = r[15:0];
        case (kind)
            0:  w[15:11] = T_SHORT_IMM | {4'd0, r[20]};
            1:  w[15:11] = T_F1_Y;
            2:  w[15:11] = T_F1_AY;
            3:  w[15:11] = T_F1_XY;
            4:  w[15:11] = T_LONG_IMM;
            5:  w[15:11] = T_R_ACC0;
            6:  w[15:11] = T_R_ACC1;
            7:  w[15:11] = T_RAM_LOAD;
            8:  w[15:11] = T_RAM_STORE;
            9: begin
                w[15:11] = T_DO;
                w[10:7]  = 4'd0;  // Redo form
            end
            10: w[15:11] = T_GOTO_JA | {4'd0, r[20]};
            11: w[15:11] = T_CALL_JA | {4'd0, r[20]};
            12: begin
                w[15:11] = T_GOTO_B;
                if (r[24]) w[10:8] = 3'd1;  // iret
            end
            13: begin
                w[15:11] = T_IF_CON;
                w[10]    = (r[27:26] == 2'd0);
            end
            default: w[15:11] = T_DO;
        endcase
        // Favour the two real destination groups
        if ((kind == 4 || kind == 7) && r[30]) w[9:7] = {1'b0, r[29], 1'b0};
        return w;
    endfunction

    function automatic word_t bad_insn();
        word_t       w;
        logic [31:0] r;
        r = $urandom;
        w = r[15:0];
        while (kept_code(w[15:11])) begin
            r = $urandom;
            w = r[15:0];
        end
        return w;
    endfunction

    function automatic seq_ctl_t model_seq(word_t w);
        seq_ctl_t s;
        t_code_t  t;
        t_code_t  pair;
        s    = '0;
        t    = w[15:11];
        pair = t & 5'b11110;
        if (pair == T_GOTO_JA || pair == T_CALL_JA || t == T_GOTO_B) begin
            s.goto_ja   = (pair == T_GOTO_JA);
            s.call_ja   = (pair == T_CALL_JA);
            s.goto_b    = (t == T_GOTO_B);
            s.iret      = (t == T_GOTO_B) && (w[10:8] == 3'd1);
            s.two_cycle = 1'b1;
            s.pc_halt   = 1'b1;
        end else if (t == T_IF_CON) begin
            s.con_check = !w[10];
        end else if (t == T_DO) begin
            s.do_start  = 1'b1;
            s.do_data   = w[10:0];
            s.two_cycle = (w[10:7] == 4'd0);
            s.pc_halt   = s.two_cycle;
        end else if (t == T_LONG_IMM) begin
            s.two_cycle = 1'b1;
        end else if (t inside {T_R_ACC0, T_R_ACC1, T_RAM_LOAD, T_RAM_STORE}) begin
            s.two_cycle = 1'b1;
            s.pc_halt   = 1'b1;
        end else if (!kept_code(t)) begin
            s.fault = 1'b1;
        end
        return s;
    endfunction

    function automatic move_ctl_t model_moves(word_t w);
        move_ctl_t m;
        t_code_t   t;
        y_step_t   ys;
        m  = '0;
        t  = w[15:11];
        ys = (w[1:0] == 2'd0) ? Y_HOLD : (w[1:0] == 2'd1) ? Y_INC :
             (w[1:0] == 2'd2) ? Y_DEC : Y_STEP_J;
        if ((t & 5'b11110) == T_SHORT_IMM) begin
            m.short_load = 1'b1;
            m.short_imm  = w[8:0];
            m.r_field    = w[11:9] ^ SHORT_R_FLIP;
        end else if (t == T_LONG_IMM) begin
            m.long_load    = (w[9:7] == DEST_YAAU);
            m.dau_imm_load = (w[9:7] == DEST_DAU);
            m.r_field      = w[6:4];
        end else if (t == T_R_ACC0 || t == T_R_ACC1) begin
            m.r_field      = w[6:4];
            m.a_field      = {1'b1, w[12]};
            m.acc_sel      = 1'b1;
            m.acc_load     = (w[8:7] == 2'd0);
            m.dau_acc_load = (w[8:7] == 2'd2);
        end else if (t == T_RAM_LOAD || t == T_RAM_STORE) begin
            m.rsel         = w[8:6];
            m.r_field      = w[6:4];
            m.ram_we       = (t == T_RAM_STORE);
            m.ram_load     = (t == T_RAM_LOAD) && !w[10] && (w[9:7] == DEST_YAAU);
            m.dau_ram_load = (t == T_RAM_LOAD) && !w[10] && (w[9:7] == DEST_DAU);
        end else if (t == T_F1_Y || t == T_F1_AY) begin
            m.dau_dec_en  = 1'b1;
            m.a_field     = w[10:9];
            m.dau_acc_ram = w[11];
            m.st_a0h      = w[11] && w[10];
            m.st_a1h      = w[11] && !w[10];
        end else if (t == T_F1_XY) begin
            m.dau_dec_en   = 1'b1;
            m.dau_ram_load = 1'b1;
        end
        // Y pointer post-modify is shared by RAM and F1 groups
        if (t inside {T_RAM_LOAD, T_RAM_STORE, T_F1_Y, T_F1_AY, T_F1_XY}) begin
            m.post_load = 1'b1;
            m.y_field   = w[3:2];
            m.y_step    = ys;
        end
        return m;
    endfunction

    // Advance the model by one rising edge
    task automatic model_clock();
        seq_ctl_t s;
        logic     con_ok;
        if (cen) begin
            if (exp_second) begin
                s          = '0;
                s.fault    = exp_seq.fault;
                exp_seq    = s;
                exp_moves  = '0;
                exp_second = 1'b0;
            end else begin
                s          = model_seq(insn);
                con_ok     = !exp_seq.con_check || con_result;
                s.goto_ja  = s.goto_ja && con_ok;
                s.call_ja  = s.call_ja && con_ok;
                s.goto_b   = s.goto_b && (con_ok || s.iret);
                s.fault    = s.fault || exp_seq.fault;
                exp_second = s.two_cycle;
                exp_seq    = s;
                exp_moves  = model_moves(insn);
            end
        end
    endtask

    function automatic logic [15:0] field_group(seq_ctl_t s, move_ctl_t m, int g);
        case (g)
            0:  return 16'({s.goto_ja, s.call_ja, s.goto_b, s.iret});
            1:  return 16'(s.con_check);
            2:  return 16'({s.do_start, s.do_data});
            3:  return 16'({s.two_cycle, s.pc_halt});
            4:  return 16'(s.fault);
            5:  return 16'({m.short_load, m.long_load, m.acc_load, m.ram_load, m.ram_we});
            6:  return 16'({m.post_load, m.y_field, m.y_step});
            7:  return 16'({m.r_field, m.rsel});
            8:  return 16'({m.a_field, m.acc_sel});
            9:  return 16'({m.dau_dec_en, m.dau_imm_load, m.dau_acc_load,
                            m.dau_ram_load, m.dau_acc_ram});
            10: return 16'({m.st_a0h, m.st_a1h});
            default: return 16'(m.short_imm);
        endcase
    endfunction

    task automatic check_val(input string what, input logic [15:0] got,
                             input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_outputs();
        for (int g = 0; g < 12; g++) begin
            check_val(group_name[g], field_group(seq, moves, g),
                      field_group(exp_seq, exp_moves, g));
        end
        check_val("no_int", 16'(no_int), 16'(!exp_second));
        check_val("long_imm", long_imm, insn);
    endtask

    // Drive at the falling edge, check at the next one
    task automatic step(input word_t w, input logic c, input logic cr);
        insn       = w;
        cen        = c;
        con_result = cr;
        @(posedge clk);
        model_clock();
        @(negedge clk);
        check_outputs();
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst        = 1'b0;
        exp_seq    = '0;
        exp_moves  = '0;
        exp_second = 1'b0;
    endtask

    task automatic end_test(input string name);
        int e;
        e = errors - test_errors_at;
        test_no++;
        if (e != 0) tests_failed++;
        $display("test %0d %s: %s (%0d errors)", test_no, name, (e == 0) ? "ok" : "failed", e);
        test_errors_at = errors;
    endtask

    task automatic check_fault(input string when);
        checks++;
        if (!seq.fault) begin
            errors++;
            $display("ERR t=%0t seq.fault low %s", $time, when);
        end
    endtask

    initial begin
        int assert_fails;
        rst            = 1'b1;
        cen            = 1'b0;
        insn           = '0;
        con_result     = 1'b0;
        errors         = 0;
        checks         = 0;
        test_errors_at = 0;
        tests_failed   = 0;
        test_no        = 0;
        void'($urandom(32'h2aa5));

        apply_reset();
        check_outputs();
        end_test("reset values");

        repeat (N_ITER) step(pick_insn(rand_below(4)), 1'b1, coin());
        end_test("single-cycle decode");

        repeat (N_ITER) begin
            step(pick_insn(4 + rand_below(9)), 1'b1, coin());
            step(pick_insn(rand_below(15)), 1'b1, coin()); // Dropped by the stage
        end
        end_test("two-cycle suppression");

        repeat (N_ITER) begin
            step(pick_insn(13), 1'b1, coin());
            step(pick_insn(10 + rand_below(3)), 1'b1, coin());
            step(pick_insn(rand_below(15)), 1'b1, coin());
        end
        end_test("conditional branches");

        repeat (N_ITER) step(pick_insn(rand_below(15)), rand_below(3) != 0, coin());
        end_test("cen gaps");

        step(pick_insn(0), 1'b1, coin()); // Leaves no second cycle pending
        step(bad_insn(), 1'b1, coin());
        check_fault("after an unsupported T code");
        repeat (N_ITER) step(pick_insn(rand_below(15)), 1'b1, coin());
        check_fault("before the final reset");
        apply_reset();
        check_outputs();
        end_test("sticky fault");

        assert_fails = dut0.u_issue_stage.u_assert.branch_fails +
                       dut0.u_issue_stage.u_assert.second_fails +
                       dut0.u_issue_stage.u_assert.fault_fails;
        if (assert_fails != 0) begin
            $display("Bound assertions failed %0d times", assert_fails);
            errors += assert_fails;
        end
        $display("checks %0d, errors %0d, tests failed %0d of %0d",
                 checks, errors, tests_failed, test_no);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* list.f */
verilog/dsp_ctrl_pkg.sv
verilog/seq_decode.sv
verilog/move_decode.sv
verilog/issue_stage.sv
verilog/dsp_ctrl.sv
sim/dsp_ctrl_assert.sv
sim/tb_dsp_ctrl.sv

/* run.sh */
#!/bin/sh
# Build and run the decode and issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_dsp_ctrl \
    -Mdir obj_dir -o sim_dsp_ctrl
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_dsp_ctrl +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
